/* rtl/scc_pkg.sv */
// ----------------------------------------
// shared constants and types of the
// wavetable sound generator: bus address
// views, channel registers, ram request
// ----------------------------------------
`default_nettype none

package scc_pkg;

	// channel count and wave geometry
	localparam int NUM_CHANNELS = 5;
	localparam int WAVE_LENGTH  = 32;
	// mixed sample width, 5 x 8-bit offset values
	localparam int MIX_WIDTH    = 11;
	// upper nibble of the register page
	localparam logic [3:0] REG_PAGE = 4'hA;

	// wave ram location, addresses 0x00..0x9f
	typedef struct packed {
		logic [2:0] channel;
		logic [4:0] index;
	} wave_addr_t;

	// register location, 0..9 freq, 10..14 volume, 15 enable mask
	typedef struct packed {
		logic [3:0] page;
		logic [3:0] field;
	} reg_addr_t;

	// same bus address seen two ways
	typedef union packed {
		wave_addr_t wave;
		reg_addr_t  regs;
	} bus_addr_u;

	typedef struct packed {
		logic [11:0] period;
		logic [3:0]  volume;
		logic        enable;
	} channel_regs_t;

	typedef struct packed {
		logic       we;
		wave_addr_t addr;
		logic [7:0] wdata;
	} ram_req_t;

	// 0 is the round boundary, 1..5 are channels a..e
	typedef logic [2:0] slot_t;

endpackage

`default_nettype wire

/* rtl/scc_bus_decoder.sv */
// ----------------------------------------
// cpu bus decoder: wave ram requests,
// channel registers, counter restarts
// and the read-valid pulse
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scc_bus_decoder
	import scc_pkg::*;
(
	input  wire                                 clk,
	input  wire                                 nreset,
	input  wire                                 bus_wr,
	input  wire                                 bus_rd,
	input  wire bus_addr_u                      bus_addr,
	input  wire [7:0]                           bus_wdata,
	output ram_req_t                            cpu_req,
	output logic                                cpu_access,
	output channel_regs_t [NUM_CHANNELS-1:0]    regs,
	output logic [NUM_CHANNELS-1:0]             restart,
	output logic                                bus_rvalid,
	output logic                                rd_wave
);

	logic       is_wave;
	logic       is_reg;
	logic       reg_write;
	logic [2:0] freq_ch;
	logic [2:0] vol_ch;

	// ----------------------------------------
	// address decode
	// ----------------------------------------
	// wave ram occupies 0x00..0x9f
	assign is_wave   = (bus_addr < 8'hA0);
	assign is_reg    = (bus_addr.regs.page == REG_PAGE);
	assign reg_write = bus_wr && is_reg;

	// frequency fields come in pairs per channel
	assign freq_ch = bus_addr.regs.field[3:1];
	// volume fields 10..14 map to a..e
	assign vol_ch  = 3'(bus_addr.regs.field - 4'd10);

	// ram side sees the strobe in the same cycle
	assign cpu_access    = (bus_wr || bus_rd) && is_wave;
	assign cpu_req.we    = bus_wr;
	assign cpu_req.addr  = bus_addr.wave;
	assign cpu_req.wdata = bus_wdata;

	// ----------------------------------------
	// channel registers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			regs    <= '0;
			restart <= '0;
		end else begin
			restart <= '0;
			if (reg_write) begin
				if (bus_addr.regs.field < 4'd10) begin
					if (bus_addr.regs.field[0]) begin
						regs[freq_ch].period[11:8] <= bus_wdata[3:0];
						// restart lands a cycle later, with the new period in place
						restart[freq_ch] <= 1'b1;
					end else begin
						regs[freq_ch].period[7:0] <= bus_wdata;
					end
				end else if (bus_addr.regs.field < 4'd15) begin
					regs[vol_ch].volume <= bus_wdata[3:0];
				end else begin
					// enable mask, bit 0 is channel a
					for (int i = 0; i < NUM_CHANNELS; i++) begin
						regs[i].enable <= bus_wdata[i];
					end
				end
			end
		end
	end

	// ----------------------------------------
	// read response
	// ----------------------------------------
	// rvalid one cycle after rd, rd_wave gates ram data
	always_ff @(posedge clk) begin
		if (!nreset) begin
			bus_rvalid <= 1'b0;
			rd_wave    <= 1'b0;
		end else begin
			bus_rvalid <= bus_rd;
			rd_wave    <= bus_rd && is_wave;
		end
	end

	// one strobe at a time on the bus
	a_no_wr_rd_overlap: assert property (
		@(posedge clk) disable iff (!nreset) !(bus_wr && bus_rd)
	);

endmodule

`default_nettype wire

/* rtl/scc_wave_ram.sv */
// ----------------------------------------
// 160-byte wave memory, one port,
// registered read
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scc_wave_ram
	import scc_pkg::*;
(
	input  wire           clk,
	input  wire ram_req_t ram_req,
	output logic [7:0]    rdata
);

	localparam int DEPTH = NUM_CHANNELS * WAVE_LENGTH;

	logic [7:0] mem [DEPTH];
	logic [7:0] ram_index;

	// channel * 32 + sample index
	assign ram_index = 8'(ram_req.addr.channel) * 8'(WAVE_LENGTH) + 8'(ram_req.addr.index);

	always_ff @(posedge clk) begin
		if (ram_req.we && (ram_index < 8'(DEPTH))) begin
			mem[ram_index] <= ram_req.wdata;
		end
		// data valid one cycle after the address
		rdata <= mem[ram_index];
	end

endmodule

`default_nettype wire

/* rtl/scc_tone_generator_5ch.sv */
// ----------------------------------------
// five period counters and wave indices,
// one channel touched per slot
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scc_tone_generator_5ch
	import scc_pkg::*;
(
	input  wire                                 clk,
	input  wire                                 nreset,
	input  wire slot_t                          slot,
	input  wire                                 step,
	input  wire channel_regs_t [NUM_CHANNELS-1:0] regs,
	input  wire [NUM_CHANNELS-1:0]              restart,
	output logic [4:0]                          wave_index,
	output logic                                sample_fetch
);

	logic [11:0] count [NUM_CHANNELS];
	logic [4:0]  index [NUM_CHANNELS];
	logic        slot_valid;
	logic [2:0]  cur_ch;

	// slot 1..5 selects channel a..e
	assign slot_valid = (slot != '0) && (slot <= slot_t'(NUM_CHANNELS));
	assign cur_ch     = slot_valid ? 3'(slot - 3'd1) : 3'd0;

	// ----------------------------------------
	// current slot view, same cycle as ram address
	// ----------------------------------------
	assign wave_index = slot_valid ? index[cur_ch] : 5'd0;
	// fetch the current index, then advance it
	// a restart in the same cycle cancels the fetch
	assign sample_fetch = step && slot_valid && (count[cur_ch] == 12'd0)
		&& !restart[cur_ch];

	// ----------------------------------------
	// counters
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			for (int i = 0; i < NUM_CHANNELS; i++) begin
				count[i] <= '0;
				index[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_CHANNELS; i++) begin
				if (restart[i]) begin
					// restart wins over a step
					count[i] <= regs[i].period;
					index[i] <= '0;
				end else if (step && slot_valid && (cur_ch == 3'(i))) begin
					if (count[i] == 12'd0) begin
						count[i] <= regs[i].period;
						// wraps at 32 by width
						index[i] <= index[i] + 5'd1;
					end else begin
						count[i] <= count[i] - 12'd1;
					end
				end
			end
		end
	end

	// decoder raises one restart per high-nibble write
	a_restart_onehot: assert property (
		@(posedge clk) disable iff (!nreset) $onehot0(restart)
	);

endmodule

`default_nettype wire

/* rtl/scc_channel_mixer.sv */
// ----------------------------------------
// slot sequencer, ram port arbitration,
// sample latches, volume scaling and
// round accumulator
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scc_channel_mixer
	import scc_pkg::*;
(
	input  wire                                   clk,
	input  wire                                   nreset,
	input  wire ram_req_t                         cpu_req,
	input  wire                                   cpu_access,
	input  wire channel_regs_t [NUM_CHANNELS-1:0] regs,
	input  wire [4:0]                             wave_index,
	input  wire                                   sample_fetch,
	input  wire [7:0]                             ram_rdata,
	output slot_t                                 slot,
	output logic                                  step,
	output ram_req_t                              ram_req,
	output logic [MIX_WIDTH-1:0]                  mix_sample,
	output logic                                  mix_strobe
);

	logic                  advance;
	logic [2:0]            fetch_ch;
	logic                  fetch_d;
	slot_t                 slot_d;
	logic [7:0]            sample_latch [NUM_CHANNELS];
	logic signed [7:0]     cur_sample;
	logic signed [12:0]    product;
	logic signed [8:0]     scaled;
	logic signed [8:0]     gated;
	logic [8:0]            offset_val;
	logic [MIX_WIDTH-1:0]  acc;

	// ----------------------------------------
	// slot sequencer
	// ----------------------------------------
	// cpu wave access owns the port, hold one cycle
	assign advance  = !cpu_access;
	assign step     = advance && (slot != '0);
	assign fetch_ch = (slot == '0) ? 3'd0 : 3'(slot - 3'd1);

	always_ff @(posedge clk) begin
		if (!nreset) begin
			slot <= '0;
		end else if (advance) begin
			slot <= (slot == slot_t'(NUM_CHANNELS)) ? slot_t'(0) : slot_t'(slot + 3'd1);
		end
	end

	// ram port, cpu first
	always_comb begin
		if (cpu_access) begin
			ram_req = cpu_req;
		end else begin
			ram_req.we           = 1'b0;
			ram_req.addr.channel = fetch_ch;
			ram_req.addr.index   = wave_index;
			ram_req.wdata        = 8'd0;
		end
	end

	// ----------------------------------------
	// sample latches
	// ----------------------------------------
	// ram data arrives one cycle after the fetch slot
	always_ff @(posedge clk) begin
		if (!nreset) begin
			fetch_d <= 1'b0;
			slot_d  <= '0;
			for (int i = 0; i < NUM_CHANNELS; i++) begin
				sample_latch[i] <= '0;
			end
		end else begin
			fetch_d <= sample_fetch;
			slot_d  <= slot;
			if (fetch_d && (slot_d != '0)) begin
				sample_latch[3'(slot_d - 3'd1)] <= ram_rdata;
			end
		end
	end

	// ----------------------------------------
	// scaling
	// ----------------------------------------
	assign cur_sample = (slot != '0) ? $signed(sample_latch[fetch_ch]) : 8'sd0;
	// signed sample times unsigned 4-bit volume
	assign product    = cur_sample * $signed({1'b0, regs[fetch_ch].volume});
	assign scaled     = 9'(product >>> 4);
	assign gated      = regs[fetch_ch].enable ? scaled : 9'sd0;
	// offset binary, 8..247
	assign offset_val = gated + 9'sd128;

	// ----------------------------------------
	// round accumulator
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			acc        <= '0;
			mix_sample <= '0;
			mix_strobe <= 1'b0;
		end else begin
			mix_strobe <= 1'b0;
			if (step) begin
				acc <= acc + MIX_WIDTH'(offset_val);
			end else if (advance) begin
				// slot 0, round complete
				mix_sample <= acc;
				mix_strobe <= 1'b1;
				acc        <= '0;
			end
		end
	end

	a_slot_range: assert property (
		@(posedge clk) disable iff (!nreset) slot <= slot_t'(NUM_CHANNELS)
	);

	// only a decoded cpu wave write may reach the ram
	a_we_from_cpu: assert property (
		@(posedge clk) disable iff (!nreset) ram_req.we |-> cpu_access
	);

endmodule

`default_nettype wire

/* rtl/scc_delta_sigma_dac.sv */
// ----------------------------------------
// output sample register and first-order
// 1-bit delta-sigma modulator
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scc_delta_sigma_dac #(
	parameter int SAMPLE_WIDTH = 11
) (
	input  wire                    clk,
	input  wire                    nreset,
	input  wire [SAMPLE_WIDTH-1:0] mix_sample,
	input  wire                    mix_strobe,
	output logic [SAMPLE_WIDTH-1:0] sample_out,
	output logic                   sample_valid,
	output logic                   dac_out
);

	// error accumulator plus carry
	logic [SAMPLE_WIDTH:0] acc;

	// hold the last round's sum
	always_ff @(posedge clk) begin
		if (!nreset) begin
			sample_out   <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= mix_strobe;
			if (mix_strobe) begin
				sample_out <= mix_sample;
			end
		end
	end

	// carry out density tracks sample_out / 2^SAMPLE_WIDTH
	always_ff @(posedge clk) begin
		if (!nreset) begin
			acc <= '0;
		end else begin
			acc <= {1'b0, acc[SAMPLE_WIDTH-1:0]} + {1'b0, sample_out};
		end
	end

	assign dac_out = acc[SAMPLE_WIDTH];

endmodule

`default_nettype wire

/* rtl/scc_core.sv */
// ----------------------------------------
// wavetable sound generator top level
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module scc_core
	import scc_pkg::*;
(
	input  wire                  clk,
	input  wire                  nreset,
	input  wire                  bus_wr,
	input  wire                  bus_rd,
	input  wire [7:0]            bus_addr,
	input  wire [7:0]            bus_wdata,
	output logic [7:0]           bus_rdata,
	output logic                 bus_rvalid,
	output logic [MIX_WIDTH-1:0] sample_out,
	output logic                 sample_valid,
	output logic                 dac_out
);

	ram_req_t                          cpu_req;
	logic                              cpu_access;
	channel_regs_t [NUM_CHANNELS-1:0]  regs;
	logic [NUM_CHANNELS-1:0]           restart;
	logic                              rd_wave;
	slot_t                             slot;
	logic                              step;
	logic [4:0]                        wave_index;
	logic                              sample_fetch;
	ram_req_t                          ram_req;
	logic [7:0]                        ram_rdata;
	logic [MIX_WIDTH-1:0]              mix_sample;
	logic                              mix_strobe;

	// ----------------------------------------
	// input side
	// ----------------------------------------
	scc_bus_decoder u_bus_decoder (
		.clk        (clk),
		.nreset     (nreset),
		.bus_wr     (bus_wr),
		.bus_rd     (bus_rd),
		.bus_addr   (bus_addr),
		.bus_wdata  (bus_wdata),
		.cpu_req    (cpu_req),
		.cpu_access (cpu_access),
		.regs       (regs),
		.restart    (restart),
		.bus_rvalid (bus_rvalid),
		.rd_wave    (rd_wave)
	);

	// register reads return zero
	assign bus_rdata = rd_wave ? ram_rdata : 8'd0;

	scc_wave_ram u_wave_ram (
		.clk     (clk),
		.ram_req (ram_req),
		.rdata   (ram_rdata)
	);

	// ----------------------------------------
	// processing
	// ----------------------------------------
	scc_tone_generator_5ch u_tone_generator (
		.clk          (clk),
		.nreset       (nreset),
		.slot         (slot),
		.step         (step),
		.regs         (regs),
		.restart      (restart),
		.wave_index   (wave_index),
		.sample_fetch (sample_fetch)
	);

	scc_channel_mixer u_channel_mixer (
		.clk          (clk),
		.nreset       (nreset),
		.cpu_req      (cpu_req),
		.cpu_access   (cpu_access),
		.regs         (regs),
		.wave_index   (wave_index),
		.sample_fetch (sample_fetch),
		.ram_rdata    (ram_rdata),
		.slot         (slot),
		.step         (step),
		.ram_req      (ram_req),
		.mix_sample   (mix_sample),
		.mix_strobe   (mix_strobe)
	);

	// output side
	scc_delta_sigma_dac #(
		.SAMPLE_WIDTH (MIX_WIDTH)
	) u_delta_sigma_dac (
		.clk          (clk),
		.nreset       (nreset),
		.mix_sample   (mix_sample),
		.mix_strobe   (mix_strobe),
		.sample_out   (sample_out),
		.sample_valid (sample_valid),
		.dac_out      (dac_out)
	);

endmodule

`default_nettype wire

/* tests/tb_scc_core.sv */
// ----------------------------------------
// testbench of the wavetable generator
// with lfsr stimulus, a cycle model of the
// channel rounds, a comparator and a watchdog
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_scc_core
	import scc_pkg::*;
();

	localparam int CLK_PERIOD     = 100;
	// rounds waited for over all phases
	localparam int PLANNED_ROUNDS = 240;
	// bus traffic and the dac window
	localparam int SETUP_CYCLES   = 3000;
	localparam int TIMEOUT_NS     = (PLANNED_ROUNDS * 10 + SETUP_CYCLES) * CLK_PERIOD;
	localparam int WAVE_BYTES     = NUM_CHANNELS * WAVE_LENGTH;

	logic                 clk;
	logic                 nreset;
	logic                 bus_wr;
	logic                 bus_rd;
	logic [7:0]           bus_addr;
	logic [7:0]           bus_wdata;
	wire  [7:0]           bus_rdata;
	wire                  bus_rvalid;
	wire  [MIX_WIDTH-1:0] sample_out;
	wire                  sample_valid;
	wire                  dac_out;

	logic [15:0]   lfsr_state;
	logic [7:0]    wave_bytes [WAVE_BYTES];
	int            errors;
	int            samples_checked;
	int            reads_checked;
	int            stalled_rounds;
	int            gap_cycles;

	// model state
	channel_regs_t m_regs [NUM_CHANNELS];
	int            m_count [NUM_CHANNELS];
	int            m_index [NUM_CHANNELS];
	logic [7:0]    m_latch [NUM_CHANNELS];
	logic [7:0]    m_mem [WAVE_BYTES];
	logic [4:0]    m_restart;
	int            m_slot;
	int            m_acc;
	int            m_round_cycles;
	logic          m_first_round;
	logic          m_fetch_pend;
	int            m_fetch_ch;
	logic [7:0]    m_fetch_data;
	int            exp_sample_q [$];
	int            exp_gap_q [$];

	scc_core u_dut (
		.clk          (clk),
		.nreset       (nreset),
		.bus_wr       (bus_wr),
		.bus_rd       (bus_rd),
		.bus_addr     (bus_addr),
		.bus_wdata    (bus_wdata),
		.bus_rdata    (bus_rdata),
		.bus_rvalid   (bus_rvalid),
		.sample_out   (sample_out),
		.sample_valid (sample_valid),
		.dac_out      (dac_out)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// ----------------------------------------
	// random source and reference
	// ----------------------------------------
	// taps 16 14 13 11 with the new bit shifted in at bit 0
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic int take_bits(input int n);
		int r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = (r << 1) | int'(lfsr_state[0]);
		end
		return r;
	endfunction

	// signed sample times volume, floored /16 and offset by 128
	function automatic int scaled_value(input logic [7:0] sample, input channel_regs_t r);
		int prod;
		prod = int'($signed(sample)) * int'(r.volume);
		if (!r.enable) begin
			return 128;
		end
		return (prod >>> 4) + 128;
	endfunction

	task automatic model_reset();
		for (int i = 0; i < NUM_CHANNELS; i++) begin
			m_regs[i]  = '0;
			m_count[i] = 0;
			m_index[i] = 0;
			m_latch[i] = '0;
		end
		m_restart      = '0;
		m_slot         = 0;
		m_acc          = 0;
		m_round_cycles = 0;
		m_first_round  = 1'b1;
		m_fetch_pend   = 1'b0;
		exp_sample_q.delete();
		exp_gap_q.delete();
	endtask

	// one clock of the generator driven by this cycle's inputs
	task automatic model_cycle();
		logic       wave_acc;
		logic [4:0] rst_next;
		logic       nf_valid;
		int         nf_ch;
		logic [7:0] nf_data;
		int         ch;
		int         fld;
		wave_acc = (bus_wr || bus_rd) && (bus_addr < 8'hA0);
		rst_next = '0;
		nf_valid = 1'b0;
		nf_ch    = 0;
		nf_data  = '0;
		fld      = int'(bus_addr[3:0]);
		m_round_cycles++;
		// a cpu wave access holds the slot
		if (!wave_acc) begin
			if (m_slot == 0) begin
				exp_sample_q.push_back(m_acc);
				exp_gap_q.push_back(m_first_round ? 0 : m_round_cycles);
				m_first_round  = 1'b0;
				m_round_cycles = 0;
				m_acc          = 0;
			end else begin
				ch = m_slot - 1;
				m_acc += scaled_value(m_latch[ch], m_regs[ch]);
				if (!m_restart[ch]) begin
					if (m_count[ch] == 0) begin
						nf_valid    = 1'b1;
						nf_ch       = ch;
						nf_data     = m_mem[ch * WAVE_LENGTH + m_index[ch]];
						m_count[ch] = int'(m_regs[ch].period);
						m_index[ch] = (m_index[ch] + 1) % WAVE_LENGTH;
					end else begin
						m_count[ch]--;
					end
				end
			end
			m_slot = (m_slot == NUM_CHANNELS) ? 0 : m_slot + 1;
		end
		for (int i = 0; i < NUM_CHANNELS; i++) begin
			if (m_restart[i]) begin
				m_count[i] = int'(m_regs[i].period);
				m_index[i] = 0;
			end
		end
		// byte read last cycle lands in its latch
		if (m_fetch_pend) begin
			m_latch[m_fetch_ch] = m_fetch_data;
		end
		m_fetch_pend = nf_valid;
		m_fetch_ch   = nf_ch;
		m_fetch_data = nf_data;
		if (bus_wr && (bus_addr[7:4] == REG_PAGE)) begin
			if (fld < 10) begin
				if (fld % 2 == 1) begin
					m_regs[fld / 2].period[11:8] = bus_wdata[3:0];
					rst_next[fld / 2] = 1'b1;
				end else begin
					m_regs[fld / 2].period[7:0] = bus_wdata;
				end
			end else if (fld < 15) begin
				m_regs[fld - 10].volume = bus_wdata[3:0];
			end else begin
				for (int i = 0; i < NUM_CHANNELS; i++) begin
					m_regs[i].enable = bus_wdata[i];
				end
			end
		end
		if (bus_wr && (bus_addr < 8'hA0)) begin
			m_mem[bus_addr] = bus_wdata;
		end
		m_restart = rst_next;
	endtask

	always @(negedge clk) begin
		if (!nreset) begin
			model_reset();
		end else begin
			model_cycle();
		end
	end

	// ----------------------------------------
	// comparator
	// ----------------------------------------
	always @(negedge clk) begin
		int exp_sample;
		int exp_gap;
		if (!nreset) begin
			gap_cycles = 0;
		end else begin
			gap_cycles++;
			if (sample_valid) begin
				if (exp_sample_q.size() == 0) begin
					$display("sample_valid at %0t with no finished round in the model", $time);
					errors++;
				end else begin
					exp_sample = exp_sample_q.pop_front();
					exp_gap    = exp_gap_q.pop_front();
					if (sample_out !== MIX_WIDTH'(exp_sample)) begin
						$display("MISMATCH at %0t: sample_out expected %0d got %0d",
							$time, exp_sample, sample_out);
						errors++;
					end
					// first round after reset has no previous strobe
					if ((exp_gap != 0) && (gap_cycles != exp_gap)) begin
						$display("MISMATCH at %0t: sample_valid spacing expected %0d got %0d",
							$time, exp_gap, gap_cycles);
						errors++;
					end
					if (gap_cycles > 6) begin
						stalled_rounds++;
					end
					samples_checked++;
				end
				gap_cycles = 0;
			end
		end
	end

	// ----------------------------------------
	// bus tasks
	// ----------------------------------------
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic bus_write(input logic [7:0] addr, input logic [7:0] data);
		bus_wr    = 1'b1;
		bus_addr  = addr;
		bus_wdata = data;
		if (addr < 8'hA0) begin
			wave_bytes[addr] = data;
		end
		next_cycle();
		bus_wr = 1'b0;
	endtask

	// read data is due exactly one cycle after the strobe
	task automatic bus_read_check(input logic [7:0] addr, input logic [7:0] expected);
		bus_rd   = 1'b1;
		bus_addr = addr;
		next_cycle();
		bus_rd = 1'b0;
		@(negedge clk);
		if (!bus_rvalid) begin
			$display("no bus_rvalid one cycle after read of 0x%02h at %0t", addr, $time);
			errors++;
		end else if (bus_rdata !== expected) begin
			$display("MISMATCH at %0t: bus_rdata expected 0x%02h got 0x%02h",
				$time, expected, bus_rdata);
			errors++;
		end
		reads_checked++;
		next_cycle();
	endtask

	task automatic wait_samples(input int count, input logic expect_silence);
		int seen;
		int idle;
		seen = 0;
		idle = 0;
		while (seen < count) begin
			@(negedge clk);
			idle++;
			if (sample_valid) begin
				seen++;
				idle = 0;
				// five idle channels at mid-scale
				if (expect_silence && (sample_out !== MIX_WIDTH'(5 * 128))) begin
					$display("MISMATCH at %0t: sample_out expected %0d got %0d",
						$time, 5 * 128, sample_out);
					errors++;
				end
			end else if (idle > 40) begin
				$display("sample_valid missing for 40 cycles at %0t", $time);
				errors++;
				seen = count;
			end
		end
		next_cycle();
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		int ones;
		int addr;
		clk             = 1'b0;
		nreset          = 1'b0;
		bus_wr          = 1'b0;
		bus_rd          = 1'b0;
		bus_addr        = '0;
		bus_wdata       = '0;
		lfsr_state      = 16'd18;
		errors          = 0;
		samples_checked = 0;
		reads_checked   = 0;
		stalled_rounds  = 0;
		repeat (8) @(posedge clk);
		#1;
		nreset = 1'b1;

		// first round after reset sums nothing
		wait_samples(1, 1'b0);
		wait_samples(20, 1'b1);

		// wave ram fill and readback
		for (int a = 0; a < WAVE_BYTES; a++) begin
			bus_write(8'(a), 8'(take_bits(8)));
		end
		for (int a = 0; a < WAVE_BYTES; a++) begin
			bus_read_check(8'(a), wave_bytes[a]);
		end

		// channel b alone at full volume with a short period
		bus_write(8'hA2, 8'h03);
		bus_write(8'hA3, 8'h00);
		bus_write(8'hAB, 8'h0F);
		bus_write(8'hAF, 8'h02);
		wait_samples(24, 1'b0);
		// high nibble write sends channel b back to index 0
		bus_write(8'hA3, 8'h00);
		wait_samples(24, 1'b0);
		bus_write(8'hA2, 8'h01);
		bus_write(8'hA3, 8'h00);
		wait_samples(24, 1'b0);
		// registers read as zero
		bus_read_check(8'hA2, 8'h00);
		bus_read_check(8'hAB, 8'h00);
		bus_read_check(8'hAF, 8'h00);

		// random periods, volumes and enable mask
		for (int cfg = 0; cfg < 5; cfg++) begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
				bus_write(8'(8'hA0 + 2 * ch), 8'(take_bits(3)));
				bus_write(8'(8'hA1 + 2 * ch), 8'h00);
				bus_write(8'(8'hAA + ch), 8'(take_bits(4)));
			end
			bus_write(8'hAF, 8'(take_bits(5)));
			wait_samples(16, 1'b0);
		end

		// cpu wave traffic during playback
		bus_write(8'hAF, 8'h1F);
		for (int k = 0; k < 60; k++) begin
			repeat (take_bits(3)) next_cycle();
			addr = (take_bits(3) % NUM_CHANNELS) * WAVE_LENGTH + take_bits(5);
			if (take_bits(2) == 0) begin
				bus_read_check(8'(addr), wave_bytes[addr]);
			end else begin
				bus_write(8'(addr), 8'(take_bits(8)));
			end
		end
		wait_samples(4, 1'b0);

		// dac density on a held mid-scale sum
		bus_write(8'hAF, 8'h00);
		// the round in flight still mixes the channels stepped before the mask write
		wait_samples(1, 1'b0);
		wait_samples(2, 1'b1);
		ones = 0;
		for (int i = 0; i < 2048; i++) begin
			@(negedge clk);
			if (dac_out) begin
				ones++;
			end
			if (sample_out !== MIX_WIDTH'(5 * 128)) begin
				$display("MISMATCH at %0t: sample_out expected %0d got %0d",
					$time, 5 * 128, sample_out);
				errors++;
			end
		end
		if ((ones < 5 * 128 - 1) || (ones > 5 * 128 + 1)) begin
			$display("MISMATCH at %0t: dac_out ones expected %0d got %0d",
				$time, 5 * 128, ones);
			errors++;
		end

		if (samples_checked < 200) begin
			$display("only %0d samples were compared", samples_checked);
			errors++;
		end
		if (stalled_rounds == 0) begin
			$display("no round was stretched by a cpu wave access");
			errors++;
		end
		$display("samples checked %0d, reads checked %0d, errors %0d",
			samples_checked, reads_checked, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired at %0t before the tests finished", $time);
		$display("samples checked %0d, reads checked %0d, errors %0d",
			samples_checked, reads_checked, errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
rtl/scc_pkg.sv
rtl/scc_bus_decoder.sv
rtl/scc_wave_ram.sv
rtl/scc_tone_generator_5ch.sv
rtl/scc_channel_mixer.sv
rtl/scc_delta_sigma_dac.sv
rtl/scc_core.sv
tests/tb_scc_core.sv

/* Makefile */
# Verilator build and run of the wavetable sound generator testbench

VERILATOR ?= verilator
TOP       ?= tb_scc_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
